/* sources.f */
src/com_pkg.sv
src/com_tx_if.sv
src/com_ram.sv
src/com_cs.sv
src/com_tx.sv
src/com_rx.sv
src/com_link.sv
sim/com_peer.sv
sim/com_link_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; fails if the log reports failure.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module com_link_tb -f sources.f -o com_link_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/com_link_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
exit 0

/* sim/com_link_tb.sv */
module com_link_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 64;
    localparam int NUMOUT  = 3;
    localparam int N       = 7;
    localparam int P_ACK     = 0;
    localparam int P_NAKACK  = 1;
    localparam int P_SILENT  = 2;
    localparam int P_CORRUPT = 3;

    logic            clk = 1'b0;
    logic            rst;
    logic            ram_we;
    com_pkg::addr_t  ram_waddr;
    logic [7:0]      ram_wdata;
    logic            fs_send;
    com_pkg::btype_t send_btype;
    com_pkg::addr_t  send_dlen;
    com_pkg::addr_t  ram_addr_init;
    logic            fd_read;
    logic [7:0]      rx_byte;
    logic            rx_valid;
    logic            fd_send;
    logic            fd_txer;
    logic            fs_read;
    com_pkg::btype_t read_btype;
    logic [7:0]      read_data;
    logic            read_valid;
    logic [7:0]      tx_byte;
    logic            tx_valid;

    // test table, one entry per column.
    string       t_name [N];
    bit          t_recv [N];
    logic [3:0]  t_type [N];
    int          t_len [N];
    int          t_script [N];
    bit          t_host_ack [N];
    bit          t_txer [N];
    int          t_frames [N];
    logic [3:0]  t_rbtype [N];

    logic [7:0]  payload [256];
    logic [7:0]  rd_buf [256];
    int          rd_cnt;
    int          cycles;
    int          limit;
    int          errors;
    int          failed_tests;

    always #10 clk = ~clk;

    com_link #(
        .TIMEOUT (TIMEOUT),
        .NUMOUT  (NUMOUT)
    ) i_com_link (
        .clk (clk), .rst (rst), .ram_we (ram_we), .ram_waddr (ram_waddr),
        .ram_wdata (ram_wdata), .fs_send (fs_send), .send_btype (send_btype),
        .send_dlen (send_dlen), .ram_addr_init (ram_addr_init), .fd_read (fd_read),
        .rx_byte (rx_byte), .rx_valid (rx_valid), .fd_send (fd_send), .fd_txer (fd_txer),
        .fs_read (fs_read), .read_btype (read_btype), .read_data (read_data),
        .read_valid (read_valid), .tx_byte (tx_byte), .tx_valid (tx_valid)
    );

    com_peer i_peer (
        .clk (clk), .rst (rst), .tx_byte (tx_byte), .tx_valid (tx_valid),
        .rx_byte (rx_byte), .rx_valid (rx_valid)
    );

    always @(posedge clk) begin
        if (read_valid) begin
            rd_buf[rd_cnt % 256] <= read_data;             // payload as handed to the host.
            rd_cnt               <= rd_cnt + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic compare(input int k, input string what, input int exp, input int act);
        if (exp != act) begin
            $display("[FAIL] %s %s: expected %0h, actual %0h", t_name[k], what, exp, act);
            errors++;
        end
    endtask

    // checks one captured frame against sync, type, length, payload, checksum.
    task automatic check_frame(input int k, input int idx, input logic [3:0] btype,
                               input int len);
        logic [7:0] exp [262];
        logic [7:0] sum;
        int         st;
        exp[0] = 8'hA5;
        exp[1] = {4'h0, btype};
        exp[2] = 8'(len >> 8) & 8'h0F;
        exp[3] = 8'(len);
        for (int i = 0; i < len; i++) exp[4 + i] = payload[i];
        sum = 8'h00;
        for (int i = 1; i < len + 4; i++) sum = sum ^ exp[i];
        exp[len + 4] = sum;
        st = i_peer.f_start[idx % 64];
        compare(k, $sformatf("frame %0d length", idx), len + 5, i_peer.f_len[idx % 64]);
        if (i_peer.f_len[idx % 64] == len + 5) begin
            for (int i = 0; i < len + 5; i++) begin
                compare(k, $sformatf("frame %0d byte %0d", idx, i), exp[i],
                        i_peer.cap[(st + i) % 4096]);
            end
        end
    endtask

    task automatic run_send(input int k);
        com_pkg::addr_t base;
        int             n0;
        int             seen;
        base = com_pkg::addr_t'($urandom % 3800);
        for (int i = 0; i < t_len[k]; i++) begin
            @(posedge clk);
            ram_we    <= 1'b1;
            ram_waddr <= base + com_pkg::addr_t'(i);
            ram_wdata <= payload[i];
        end
        @(posedge clk);
        ram_we        <= 1'b0;
        fs_send       <= 1'b1;
        send_btype    <= com_pkg::btype_t'(t_type[k]);
        send_dlen     <= com_pkg::addr_t'(t_len[k]);
        ram_addr_init <= base;
        n0   = i_peer.frame_cnt;
        seen = n0;
        while (!fd_send) begin
            if (i_peer.frame_cnt != seen) begin
                seen++;
                if (t_script[k] == P_ACK || (t_script[k] == P_NAKACK && seen - n0 > 1)) begin
                    i_peer.send_frame(4'd1, 0, payload, 1'b0);
                end else if (t_script[k] == P_NAKACK) begin
                    i_peer.send_frame(4'd2, 0, payload, 1'b0);
                end
            end
            @(posedge clk);
        end
        compare(k, "fd_txer", t_txer[k], fd_txer);
        compare(k, "frames", t_frames[k], i_peer.frame_cnt - n0);
        for (int f = n0; f < i_peer.frame_cnt; f++) check_frame(k, f, t_type[k], t_len[k]);
        fs_send <= 1'b0;
        @(posedge clk);
        while (fd_send) @(posedge clk);
    endtask

    task automatic run_recv(input int k);
        int n0;
        int r0;
        int held;
        n0 = i_peer.frame_cnt;
        r0 = rd_cnt;
        i_peer.send_frame(t_type[k], t_len[k], payload, t_script[k] == P_CORRUPT);
        while (!fs_read) @(posedge clk);
        compare(k, "read_btype", t_rbtype[k], read_btype);
        compare(k, "frames", t_frames[k], i_peer.frame_cnt - n0);
        if (i_peer.frame_cnt - n0 == 1) begin
            check_frame(k, n0, (t_script[k] == P_CORRUPT) ? 4'd2 : 4'd1, 0);
        end
        compare(k, "read bytes", t_len[k], rd_cnt - r0);
        for (int i = 0; i < t_len[k] && r0 + i < rd_cnt; i++) begin
            compare(k, $sformatf("read byte %0d", i), payload[i], rd_buf[(r0 + i) % 256]);
        end
        if (t_host_ack[k]) begin
            @(posedge clk);
            fd_read <= 1'b1;
            @(posedge clk);
            while (fs_read) @(posedge clk);
            fd_read <= 1'b0;
        end else begin
            held = 0;
            while (fs_read) begin                  // the report times out on its own.
                @(posedge clk);
                held++;
            end
            if (held > TIMEOUT + 2) begin
                $display("[FAIL] %s fs_read hold: expected at most %0d, actual %0d",
                         t_name[k], TIMEOUT + 2, held);
                errors++;
            end
        end
    endtask

    task automatic set_row(input int k, input string name, input bit recv, input int len,
                           input int script, input bit host_ack, input bit txer,
                           input int frames);
        logic [3:0] kinds [7];
        kinds = '{4'd5, 4'd6, 4'd7, 4'd8, 4'd9, 4'd13, 4'd14};
        t_name[k]     = name;
        t_recv[k]     = recv;
        t_type[k]     = kinds[$urandom % 7];
        t_len[k]      = len;
        t_script[k]   = script;
        t_host_ack[k] = host_ack;
        t_txer[k]     = txer;
        t_frames[k]   = frames;
        t_rbtype[k]   = (script == P_CORRUPT) ? 4'd15 : t_type[k];
    endtask

    initial begin
        int errs_before;
        void'($urandom(32'he562));
        rst = 1'b1;
        ram_we = 1'b0;
        ram_waddr = '0;
        ram_wdata = 8'h00;
        fs_send = 1'b0;
        send_btype = com_pkg::INIT;
        send_dlen = '0;
        ram_addr_init = '0;
        fd_read = 1'b0;
        rd_cnt = 0;
        cycles = 0;
        errors = 0;
        failed_tests = 0;
        set_row(0, "send_ack",      1'b0, 16, P_ACK,     1'b0, 1'b0, 1);
        set_row(1, "send_nak_ack",  1'b0, 8,  P_NAKACK,  1'b0, 1'b0, 2);
        set_row(2, "send_silent",   1'b0, 4,  P_SILENT,  1'b0, 1'b1, NUMOUT);
        set_row(3, "recv_valid",    1'b1, 10, P_ACK,     1'b1, 1'b0, 1);
        set_row(4, "recv_corrupt",  1'b1, 6,  P_CORRUPT, 1'b1, 1'b0, 1);
        set_row(5, "recv_no_read",  1'b1, 3,  P_ACK,     1'b0, 1'b0, 1);
        set_row(6, "send_after",    1'b0, 0,  P_ACK,     1'b0, 1'b0, 1);
        limit = 0;
        for (int k = 0; k < N; k++) limit += NUMOUT * (t_len[k] + 6 + TIMEOUT + 8) * 2;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int k = 0; k < N; k++) begin
            errs_before = errors;
            for (int i = 0; i < 256; i++) payload[i] = 8'($urandom);
            if (t_recv[k]) run_recv(k);
            else run_send(k);
            if (errors == errs_before) begin
                $display("test %s: ok", t_name[k]);
            end else begin
                $display("test %s: %0d mismatches", t_name[k], errors - errs_before);
                failed_tests++;
            end
        end
        if (i_peer.bad_csum_cnt != 0) begin
            $display("the peer saw %0d frames with a wrong checksum", i_peer.bad_csum_cnt);
            errors++;
        end
        $display("tests %0d, failed %0d, mismatches %0d", N, failed_tests, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* sim/com_peer.sv */
module com_peer (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] tx_byte,
    input  logic       tx_valid,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0] cap [4096];                        // every byte the link put on the line.
    int         f_start [64];
    int         f_len [64];
    int         wr_ptr;
    int         frame_cnt;
    int         bad_csum_cnt;
    logic       in_frame;
    logic [7:0] acc;                               // ends at zero for a good checksum.

    initial begin
        rx_byte  = 8'h00;
        rx_valid = 1'b0;
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr       <= 0;
            frame_cnt    <= 0;
            bad_csum_cnt <= 0;
            in_frame     <= 1'b0;
            acc          <= 8'h00;
        end else if (tx_valid) begin
            cap[wr_ptr % 4096] <= tx_byte;
            wr_ptr             <= wr_ptr + 1;
            if (!in_frame) begin
                f_start[frame_cnt % 64] <= wr_ptr;
                in_frame                <= 1'b1;
                acc                     <= 8'h00;  // the sync byte is not summed.
            end else begin
                acc <= acc ^ tx_byte;
            end
        end else if (in_frame) begin
            f_len[frame_cnt % 64] <= wr_ptr - f_start[frame_cnt % 64];
            frame_cnt             <= frame_cnt + 1;
            in_frame              <= 1'b0;
            if (acc != 8'h00) bad_csum_cnt <= bad_csum_cnt + 1;
        end
    end

    // drives one frame, byte per cycle, with an optional bad checksum.
    task automatic send_frame(input logic [3:0] btype, input int len,
                              input logic [7:0] data [256], input bit corrupt);
        logic [7:0] sum;
        logic [7:0] frame [262];
        int         n;
        frame[0] = 8'hA5;
        frame[1] = {4'h0, btype};
        frame[2] = 8'(len >> 8) & 8'h0F;
        frame[3] = 8'(len);
        for (int i = 0; i < len; i++) frame[4 + i] = data[i];
        sum = 8'h00;
        for (int i = 1; i < len + 4; i++) sum = sum ^ frame[i];
        frame[len + 4] = corrupt ? ~sum : sum;
        n = len + 5;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            rx_byte  <= frame[i];
            rx_valid <= 1'b1;
        end
        @(posedge clk);
        rx_valid <= 1'b0;
    endtask

endmodule

/* src/com_link.sv */
module com_link #(
    parameter int TIMEOUT   = 128,
    parameter int NUMOUT    = 3,
    parameter int RAM_DEPTH = 4096
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            ram_we,
    input  com_pkg::addr_t  ram_waddr,
    input  logic [7:0]      ram_wdata,
    input  logic            fs_send,
    input  com_pkg::btype_t send_btype,
    input  com_pkg::addr_t  send_dlen,
    input  com_pkg::addr_t  ram_addr_init,
    input  logic            fd_read,
    input  logic [7:0]      rx_byte,
    input  logic            rx_valid,
    output logic            fd_send,
    output logic            fd_txer,
    output logic            fs_read,
    output com_pkg::btype_t read_btype,
    output logic [7:0]      read_data,
    output logic            read_valid,
    output logic [7:0]      tx_byte,
    output logic            tx_valid
);

    com_pkg::addr_t  ram_raddr;
    logic [7:0]      ram_rdata;
    logic            fs_rx;
    logic            fd_rx;
    com_pkg::btype_t rx_btype;

    com_tx_if tx_bus ();

    com_ram #(
        .RAM_DEPTH (RAM_DEPTH)
    ) i_com_ram (
        .clk   (clk),
        .we    (ram_we),
        .waddr (ram_waddr),
        .wdata (ram_wdata),
        .raddr (ram_raddr),
        .rdata (ram_rdata)
    );

    com_cs #(
        .TIMEOUT (TIMEOUT),
        .NUMOUT  (NUMOUT)
    ) i_com_cs (
        .clk           (clk),
        .rst           (rst),
        .fs_send       (fs_send),
        .send_btype    (send_btype),
        .send_dlen     (send_dlen),
        .ram_addr_init (ram_addr_init),
        .fd_read       (fd_read),
        .fs_rx         (fs_rx),
        .rx_btype      (rx_btype),
        .fd_send       (fd_send),
        .fd_txer       (fd_txer),
        .fs_read       (fs_read),
        .read_btype    (read_btype),
        .fd_rx         (fd_rx),
        .tx            (tx_bus)
    );

    com_tx i_com_tx (
        .clk       (clk),
        .rst       (rst),
        .ram_rdata (ram_rdata),
        .ram_raddr (ram_raddr),
        .tx_byte   (tx_byte),
        .tx_valid  (tx_valid),
        .tx        (tx_bus)
    );

    com_rx i_com_rx (
        .clk        (clk),
        .rst        (rst),
        .rx_byte    (rx_byte),
        .rx_valid   (rx_valid),
        .fd_rx      (fd_rx),
        .fs_rx      (fs_rx),
        .rx_btype   (rx_btype),
        .read_data  (read_data),
        .read_valid (read_valid)
    );

endmodule

/* src/com_rx.sv */
module com_rx (
    input  logic            clk,
    input  logic            rst,
    input  logic [7:0]      rx_byte,
    input  logic            rx_valid,
    input  logic            fd_rx,
    output logic            fs_rx,
    output com_pkg::btype_t rx_btype,
    output logic [7:0]      read_data,
    output logic            read_valid
);

    typedef enum logic [2:0] {
        R_SYNC,
        R_TYPE,
        R_LENH,
        R_LENL,
        R_DATA,
        R_CSUM,
        R_HOLD,
        R_DROP
    } state_t;

    state_t          state;
    com_pkg::addr_t  remain;
    com_pkg::addr_t  frame_len;
    com_pkg::btype_t type_q;
    logic [7:0]      len_hi;
    logic [7:0]      csum;                         // XOR of the bytes after sync.

    assign frame_len = com_pkg::addr_t'({len_hi, rx_byte});
    assign fs_rx     = (state == R_HOLD);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= R_SYNC;
            remain     <= '0;
            rx_btype   <= com_pkg::INIT;
            read_valid <= 1'b0;
        end else begin
            read_valid <= 1'b0;
            case (state)
                R_SYNC: if (rx_valid && rx_byte == com_pkg::COM_SYNC) state <= R_TYPE;
                R_TYPE: if (rx_valid) state <= R_LENH;
                R_LENH: if (rx_valid) state <= R_LENL;
                R_LENL: begin
                    if (rx_valid) begin
                        remain <= frame_len;
                        state  <= (frame_len == '0) ? R_CSUM : R_DATA;
                    end
                end
                R_DATA: begin
                    if (rx_valid) begin
                        read_valid <= 1'b1;
                        remain     <= remain - 1'b1;
                        if (remain == com_pkg::addr_t'(1)) state <= R_CSUM;
                    end
                end
                R_CSUM: begin
                    if (rx_valid) begin
                        rx_btype <= (rx_byte == csum) ? type_q : com_pkg::ERROR;
                        state    <= R_HOLD;
                    end
                end
                R_HOLD: if (fd_rx) state <= R_DROP;
                R_DROP: if (!fd_rx) state <= R_SYNC;  // line bytes are ignored until here.
                default: state <= R_SYNC;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid) begin
            case (state)
                R_TYPE: begin
                    type_q <= com_pkg::btype_t'(rx_byte[3:0]);
                    csum   <= rx_byte;
                end
                R_LENH: begin
                    len_hi <= rx_byte;
                    csum   <= csum ^ rx_byte;
                end
                R_LENL: csum <= csum ^ rx_byte;
                R_DATA: begin
                    read_data <= rx_byte;
                    csum      <= csum ^ rx_byte;
                end
                default: ;
            endcase
        end
    end

    a_btype_held: assert property (@(posedge clk) disable iff (rst)
        (fs_rx && $past(fs_rx)) |-> $stable(rx_btype));

endmodule

/* src/com_tx.sv */
module com_tx (
    input  logic           clk,
    input  logic           rst,
    input  logic [7:0]     ram_rdata,
    output com_pkg::addr_t ram_raddr,
    output logic [7:0]     tx_byte,
    output logic           tx_valid,
    com_tx_if.framer       tx
);

    typedef enum logic [3:0] {
        T_IDLE,
        T_LOAD,
        T_SYNC,
        T_TYPE,
        T_LENH,
        T_LENL,
        T_DATA,
        T_CSUM,
        T_DONE
    } state_t;

    state_t         state;
    com_pkg::addr_t remain;                        // payload bytes still to send.
    com_pkg::addr_t rd_addr;
    logic [7:0]     csum;
    logic [15:0]    len_w;

    assign len_w     = 16'(tx.ram_rlen);
    assign ram_raddr = rd_addr;
    assign tx_valid  = (state inside {T_SYNC, T_TYPE, T_LENH, T_LENL, T_DATA, T_CSUM});
    assign tx.done   = (state == T_DONE);

    always_comb begin
        case (state)
            T_SYNC:  tx_byte = com_pkg::COM_SYNC;
            T_TYPE:  tx_byte = {4'h0, tx.btype};
            T_LENH:  tx_byte = len_w[15:8];
            T_LENL:  tx_byte = len_w[7:0];
            T_DATA:  tx_byte = ram_rdata;
            T_CSUM:  tx_byte = csum;
            default: tx_byte = 8'h00;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= T_IDLE;
            remain <= '0;
        end else begin
            case (state)
                T_IDLE: if (tx.start) state <= T_LOAD;
                T_LOAD: begin
                    remain <= tx.ram_rlen;
                    state  <= T_SYNC;
                end
                T_SYNC: state <= T_TYPE;
                T_TYPE: state <= T_LENH;
                T_LENH: state <= T_LENL;
                T_LENL: state <= (remain == '0) ? T_CSUM : T_DATA;
                T_DATA: begin
                    remain <= remain - 1'b1;
                    if (remain == com_pkg::addr_t'(1)) state <= T_CSUM;
                end
                T_CSUM: state <= T_DONE;
                T_DONE: if (!tx.start) state <= T_IDLE;
                default: state <= T_IDLE;
            endcase
        end
    end

    // the read address runs one byte ahead of the payload on the line.
    always_ff @(posedge clk) begin
        if (state == T_LOAD) begin
            rd_addr <= tx.ram_init;
            csum    <= 8'h00;
        end else if (state inside {T_TYPE, T_LENH, T_LENL, T_DATA}) begin
            csum <= csum ^ tx_byte;
            if (state == T_LENL || state == T_DATA) rd_addr <= rd_addr + 1'b1;
        end
    end

    a_valid_framed: assert property (@(posedge clk) disable iff (rst)
        (!tx.start && !tx.done) |-> !tx_valid);

endmodule

/* src/com_cs.sv */
module com_cs #(
    parameter int TIMEOUT = 128,
    parameter int NUMOUT  = 3
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            fs_send,
    input  com_pkg::btype_t send_btype,
    input  com_pkg::addr_t  send_dlen,
    input  com_pkg::addr_t  ram_addr_init,
    input  logic            fd_read,
    input  logic            fs_rx,
    input  com_pkg::btype_t rx_btype,
    output logic            fd_send,
    output logic            fd_txer,
    output logic            fs_read,
    output com_pkg::btype_t read_btype,
    output logic            fd_rx,
    com_tx_if.controller    tx
);

    localparam int TW = $clog2(TIMEOUT + 1);
    localparam int NW = $clog2(NUMOUT + 1);

    typedef enum logic [3:0] {
        MAIN_WAIT,
        SEND_PREP,
        SEND_DATA,
        RANS_WAIT,
        RANS_TAKE,
        RANS_DONE,
        SEND_DONE,
        SEND_FAIL,
        READ_PREP,
        READ_DATA,
        WANS_DATA,
        READ_DONE
    } state_t;

    state_t        state;
    state_t        next_state;
    state_t        ans_goto;                       // where to go once the answer is released.
    logic [TW-1:0] time_cnt;
    logic [NW-1:0] num_cnt;                        // failed attempts so far.
    logic          time_up;
    logic          last_try;
    logic          in_send;

    assign time_up  = (time_cnt == TW'(TIMEOUT - 1));
    assign last_try = (num_cnt == NW'(NUMOUT - 1));
    assign in_send  = (state inside {SEND_PREP, SEND_DATA, RANS_WAIT, RANS_TAKE, RANS_DONE});

    assign fd_send  = (state == SEND_DONE) || (state == SEND_FAIL);
    assign fd_txer  = (state == SEND_FAIL);
    assign fs_read  = (state == READ_DONE);
    assign fd_rx    = (state == RANS_DONE) || (state == READ_DATA);
    assign tx.start = (state == SEND_DATA) || (state == WANS_DATA);

    ////////////////////////////////////////////////////////////////////////////
    // transaction sequencing

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= MAIN_WAIT;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            MAIN_WAIT: begin
                if (fs_send) begin
                    next_state = SEND_PREP;                // a send wins over a pending frame.
                end else if (fs_rx) begin
                    next_state = READ_PREP;
                end
            end
            SEND_PREP: next_state = SEND_DATA;
            SEND_DATA: if (tx.done) next_state = RANS_WAIT;
            RANS_WAIT: begin
                if (fs_rx) begin
                    next_state = RANS_TAKE;
                end else if (time_up) begin
                    next_state = last_try ? SEND_FAIL : SEND_DATA;
                end
            end
            RANS_TAKE: next_state = RANS_DONE;
            RANS_DONE: if (!fs_rx) next_state = ans_goto;
            SEND_DONE: if (!fs_send) next_state = MAIN_WAIT;
            SEND_FAIL: if (!fs_send) next_state = MAIN_WAIT;
            READ_PREP: next_state = READ_DATA;
            READ_DATA: if (!fs_rx) next_state = WANS_DATA;
            WANS_DATA: if (tx.done) next_state = READ_DONE;
            READ_DONE: if (fd_read || time_up) next_state = MAIN_WAIT;
            default:   next_state = MAIN_WAIT;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // answer timer and retry count

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            time_cnt <= '0;
            num_cnt  <= '0;
            ans_goto <= MAIN_WAIT;
        end else begin
            if (next_state == state && (state == RANS_WAIT || state == READ_DONE)) begin
                time_cnt <= time_cnt + 1'b1;
            end else begin
                time_cnt <= '0;
            end

            if (state == MAIN_WAIT) begin
                num_cnt <= '0;
            end else if (state == RANS_WAIT && !fs_rx && time_up) begin
                num_cnt <= num_cnt + 1'b1;
            end else if (state == RANS_TAKE && rx_btype == com_pkg::NAK) begin
                num_cnt <= num_cnt + 1'b1;
            end

            if (state == RANS_TAKE) begin
                if (rx_btype == com_pkg::NAK) begin
                    ans_goto <= last_try ? SEND_FAIL : SEND_DATA;
                end else begin
                    ans_goto <= SEND_DONE;             // anything but a NAK ends the send.
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            read_btype <= com_pkg::INIT;
        end else if (state == READ_PREP) begin
            read_btype <= rx_btype;
        end
    end

    // frame fields for the framer, stable while start is high.
    always_ff @(posedge clk) begin
        if (state == SEND_PREP) begin
            tx.btype    <= send_btype;
            tx.ram_init <= ram_addr_init;
            tx.ram_rlen <= send_dlen;
        end else if (state == READ_PREP) begin
            tx.btype    <= (rx_btype == com_pkg::ERROR) ? com_pkg::NAK : com_pkg::ACK;
            tx.ram_init <= '0;
            tx.ram_rlen <= '0;                         // replies carry no payload.
        end
    end

    a_send_held: assert property (@(posedge clk) disable iff (rst) in_send |-> fs_send);

    a_txer_count: assert property (@(posedge clk) disable iff (rst)
        fd_txer |-> (num_cnt == NW'(NUMOUT)));

endmodule

/* src/com_ram.sv */
module com_ram #(
    parameter int RAM_DEPTH = 4096
) (
    input  logic           clk,
    input  logic           we,
    input  com_pkg::addr_t waddr,
    input  logic [7:0]     wdata,
    input  com_pkg::addr_t raddr,
    output logic [7:0]     rdata
);

    logic [7:0] mem [RAM_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;                   // host side fills the payload.
        end
        rdata <= mem[raddr];                       // one cycle of read latency.
    end

endmodule

/* src/com_tx_if.sv */
interface com_tx_if;

    logic            start;                        // held until done is seen.
    logic            done;                         // held until start falls.
    com_pkg::btype_t btype;
    com_pkg::addr_t  ram_init;
    com_pkg::addr_t  ram_rlen;

    modport controller (
        output start,
        output btype,
        output ram_init,
        output ram_rlen,
        input  done
    );

    modport framer (
        input  start,
        input  btype,
        input  ram_init,
        input  ram_rlen,
        output done
    );

endinterface

/* src/com_pkg.sv */
package com_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // buffer addressing

    localparam int ADDR_W = 12;

    typedef logic [ADDR_W-1:0] addr_t;             // buffer address or payload length.

    ////////////////////////////////////////////////////////////////////////////
    // frame layout

    localparam logic [7:0] COM_SYNC = 8'hA5;       // first byte of every frame.

    typedef enum logic [3:0] {
        INIT   = 4'd0,
        ACK    = 4'd1,
        NAK    = 4'd2,
        STL    = 4'd3,
        DIDX   = 4'd5,
        DPARAM = 4'd6,
        DDIDX  = 4'd7,
        DLINK  = 4'd8,
        DTYPE  = 4'd9,
        DTEMP  = 4'd10,
        DATA0  = 4'd13,
        DATA1  = 4'd14,
        ERROR  = 4'd15                             // reported for a corrupt frame.
    } btype_t;

endpackage
